//--- src/cpuParams.svh
// core sizing macros
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH
`default_nettype none

// data and address width
`define XLEN 32

// register number width and file depth
`define REG_ADDR_W 5
`define NUM_REGS (1 << `REG_ADDR_W)

// memory depths in words
`define IMEM_WORDS 256
`define DMEM_WORDS 256

// all-ones word ends a run
`define HALT_WORD 32'hFFFF_FFFF

`default_nettype wire
`endif

//--- src/isaPkg.sv
// instruction set encodings
`default_nettype none

package isaPkg;

    // primary opcode field
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_XORI  = 6'h0E,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcodeT;

    // r-type function field
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_ADD  = 6'h20,
        F_ADDU = 6'h21,
        F_SUB  = 6'h22,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2A
    } functT;

    // Z variants take a zero-extended immediate
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_ANDZ, ALU_ORZ, ALU_XORZ
    } aluOpT;

endpackage

`default_nettype wire

//--- src/pipePkg.sv
// pipeline and host port types
`include "cpuParams.svh"
`default_nettype none

package pipePkg;

    // operand source for forwarding
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwdSelT;

    typedef enum logic [1:0] {
        LOAD_INSTR,
        RUN,
        READ_REG,
        READ_DATA
    } hostOpT;

    typedef struct packed {
        hostOpT           op;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data;
    } hostCmdT;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] instr;
        logic [`XLEN-1:0] pcPlus4;
    } ifIdT;

    typedef struct packed {
        logic                   valid;
        logic                   halt;
        isaPkg::aluOpT          aluOp;
        logic                   useImm;
        logic                   regWrite;
        logic                   memRead;
        logic                   memWrite;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] destReg;
        logic [`XLEN-1:0]       rsVal;
        logic [`XLEN-1:0]       rtVal;
        logic [`XLEN-1:0]       imm;
        logic [4:0]             shamt;
    } idExT;

    typedef struct packed {
        logic                   valid;
        logic                   halt;
        logic                   regWrite;
        logic                   memRead;
        logic                   memWrite;
        logic [`REG_ADDR_W-1:0] destReg;
        logic [`XLEN-1:0]       aluOut;
        logic [`XLEN-1:0]       storeData;
    } exMemT;

    typedef struct packed {
        logic                   valid;
        logic                   halt;
        logic                   regWrite;
        logic [`REG_ADDR_W-1:0] destReg;
        logic [`XLEN-1:0]       result;
    } memWbT;

    typedef struct packed {
        logic             redirect;
        logic [`XLEN-1:0] target;
        logic             freeze;
    } fetchCtlT;

    // operand picked by a forwarding select
    function automatic logic [`XLEN-1:0] fwdPick(input fwdSelT sel,
                                                 input logic [`XLEN-1:0] regVal,
                                                 input logic [`XLEN-1:0] memVal,
                                                 input logic [`XLEN-1:0] wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- src/fetchStage.sv
// instruction fetch stage
`timescale 1ns/1ps
`include "cpuParams.svh"
`default_nettype none

module fetchStage (
    input  logic              clock,
    input  logic              rstN,
    input  logic              run,
    input  logic              restart,
    input  logic              stall,
    input  pipePkg::fetchCtlT fetchCtl,
    input  logic              imemWrite,
    input  logic [`XLEN-1:0]  imemAddr,
    input  logic [`XLEN-1:0]  imemData,
    output pipePkg::ifIdT     ifId
);

    localparam int addrBits = $clog2(`IMEM_WORDS);

    logic [`XLEN-1:0] imem [`IMEM_WORDS];
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pcPlus4;
    logic             frozen;

    assign pcPlus4 = pc + 4;

    // host program load, only while idle
    always_ff @(posedge clock)
    begin
        if (imemWrite)
        begin
            imem[imemAddr[addrBits+1:2]] <= imemData;
        end
    end

    always_ff @(posedge clock)
    begin
        if (!rstN || restart)
        begin
            pc         <= '0;
            frozen     <= 1'b0;
            ifId.valid <= 1'b0;
        end
        else if (run && !stall)
        begin
            if (fetchCtl.redirect)
            begin
                // drop the wrongly fetched word
                pc         <= fetchCtl.target;
                ifId.valid <= 1'b0;
            end
            else if (fetchCtl.freeze)
            begin
                frozen     <= 1'b1;
                ifId.valid <= 1'b0;
            end
            else if (!frozen)
            begin
                pc           <= pcPlus4;
                ifId.valid   <= 1'b1;
                ifId.instr   <= imem[pc[addrBits+1:2]];
                ifId.pcPlus4 <= pcPlus4;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/decodeStage.sv
// instruction decode stage
`timescale 1ns/1ps
`include "cpuParams.svh"
`default_nettype none

module decodeStage (
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   run,
    input  logic                   restart,
    input  logic                   stall,
    input  pipePkg::ifIdT          ifId,
    input  pipePkg::memWbT         wb,
    input  pipePkg::exMemT         memFwd,
    input  pipePkg::fwdSelT        idFwdA,
    input  pipePkg::fwdSelT        idFwdB,
    input  logic [`REG_ADDR_W-1:0] regReadAddr,
    output logic [`XLEN-1:0]       regReadData,
    output pipePkg::idExT          idEx,
    output pipePkg::fetchCtlT      fetchCtl
);

    import isaPkg::*;
    import pipePkg::*;

    logic [`XLEN-1:0]       regs [`NUM_REGS];
    logic [`XLEN-1:0]       instr;
    opcodeT                 opcode;
    functT                  funct;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       rsVal;
    logic [`XLEN-1:0]       rtVal;
    logic [`XLEN-1:0]       brA;
    logic [`XLEN-1:0]       brB;
    logic                   isHalt;
    logic                   isBeq;
    logic                   isBne;
    logic                   isJump;
    logic                   taken;
    logic                   wbWrite;
    idExT                   idExNext;

    assign instr  = ifId.instr;
    assign opcode = opcodeT'(instr[31:26]);
    assign funct  = functT'(instr[5:0]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign imm    = {{16{instr[15]}}, instr[15:0]};
    assign isHalt = (instr == `HALT_WORD);

    assign wbWrite = run && wb.valid && wb.regWrite && (wb.destReg != '0);

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wbWrite)
        begin
            regs[wb.destReg] <= wb.result;
        end
    end

    // r0 reads zero, a same-cycle write is seen at once
    function automatic logic [`XLEN-1:0] readReg(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        if (wbWrite && wb.destReg == addr)
            return wb.result;
        return regs[addr];
    endfunction

    always_comb
    begin
        rsVal       = readReg(rs);
        rtVal       = readReg(rt);
        regReadData = readReg(regReadAddr);
    end

    // control decode
    always_comb
    begin
        idExNext         = '0;
        idExNext.valid   = 1'b1;
        idExNext.halt    = isHalt;
        idExNext.aluOp   = ALU_ADD;
        idExNext.rs      = rs;
        idExNext.rt      = rt;
        idExNext.destReg = rt;
        idExNext.rsVal   = rsVal;
        idExNext.rtVal   = rtVal;
        idExNext.imm     = imm;
        idExNext.shamt   = instr[10:6];
        isBeq            = 1'b0;
        isBne            = 1'b0;
        isJump           = 1'b0;
        case (opcode)
            OP_RTYPE:
            begin
                idExNext.regWrite = 1'b1;
                idExNext.destReg  = instr[15:11];
                case (funct)
                    F_ADD, F_ADDU: idExNext.aluOp = ALU_ADD;
                    F_SUB, F_SUBU: idExNext.aluOp = ALU_SUB;
                    F_AND:         idExNext.aluOp = ALU_AND;
                    F_OR:          idExNext.aluOp = ALU_OR;
                    F_XOR:         idExNext.aluOp = ALU_XOR;
                    F_NOR:         idExNext.aluOp = ALU_NOR;
                    F_SLT:         idExNext.aluOp = ALU_SLT;
                    F_SLL:         idExNext.aluOp = ALU_SLL;
                    F_SRL:         idExNext.aluOp = ALU_SRL;
                    F_SRA:         idExNext.aluOp = ALU_SRA;
                    default:       idExNext.regWrite = 1'b0;
                endcase
            end
            OP_ADDI, OP_ADDIU:
            begin
                idExNext.useImm   = 1'b1;
                idExNext.regWrite = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI:
            begin
                idExNext.useImm   = 1'b1;
                idExNext.regWrite = 1'b1;
                idExNext.aluOp    = (opcode == OP_ANDI) ? ALU_ANDZ :
                                    (opcode == OP_ORI)  ? ALU_ORZ : ALU_XORZ;
            end
            OP_LW:
            begin
                idExNext.useImm   = 1'b1;
                idExNext.regWrite = 1'b1;
                idExNext.memRead  = 1'b1;
            end
            OP_SW:
            begin
                idExNext.useImm   = 1'b1;
                idExNext.memWrite = 1'b1;
            end
            OP_BEQ:  isBeq = 1'b1;
            OP_BNE:  isBne = 1'b1;
            OP_J:    isJump = 1'b1;
            default: ;
        endcase
    end

    // branch resolution in ID
    always_comb
    begin
        brA   = fwdPick(idFwdA, rsVal, memFwd.aluOut, wb.result);
        brB   = fwdPick(idFwdB, rtVal, memFwd.aluOut, wb.result);
        taken = (isBeq && brA == brB) || (isBne && brA != brB);
        fetchCtl.redirect = ifId.valid && !stall && (taken || isJump);
        fetchCtl.target   = isJump ? {ifId.pcPlus4[31:28], instr[25:0], 2'b00}
                                   : ifId.pcPlus4 + {imm[29:0], 2'b00};
        fetchCtl.freeze   = ifId.valid && isHalt;
    end

    always_ff @(posedge clock)
    begin
        if (!rstN || restart)
        begin
            idEx.valid <= 1'b0;
        end
        else if (run)
        begin
            // stalled or empty slot enters EX as a bubble
            if (stall || !ifId.valid)
                idEx <= '0;
            else
                idEx <= idExNext;
        end
    end

endmodule

`default_nettype wire

//--- src/executeStage.sv
// execute stage
`timescale 1ns/1ps
`include "cpuParams.svh"
`default_nettype none

module executeStage (
    input  logic            clock,
    input  logic            rstN,
    input  logic            run,
    input  logic            restart,
    input  pipePkg::idExT   idEx,
    input  pipePkg::exMemT  memFwd,
    input  pipePkg::memWbT  wbFwd,
    input  pipePkg::fwdSelT exFwdA,
    input  pipePkg::fwdSelT exFwdB,
    output pipePkg::exMemT  exMem
);

    import isaPkg::*;
    import pipePkg::*;

    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] zeroImm;
    logic [`XLEN-1:0] aluOut;

    assign srcA    = fwdPick(exFwdA, idEx.rsVal, memFwd.aluOut, wbFwd.result);
    assign srcB    = fwdPick(exFwdB, idEx.rtVal, memFwd.aluOut, wbFwd.result);
    assign opB     = idEx.useImm ? idEx.imm : srcB;
    assign zeroImm = {16'b0, idEx.imm[15:0]};

    // shifts act on rt by shamt
    always_comb
    begin
        case (idEx.aluOp)
            ALU_ADD:  aluOut = srcA + opB;
            ALU_SUB:  aluOut = srcA - opB;
            ALU_AND:  aluOut = srcA & opB;
            ALU_OR:   aluOut = srcA | opB;
            ALU_XOR:  aluOut = srcA ^ opB;
            ALU_NOR:  aluOut = ~(srcA | opB);
            ALU_SLT:  aluOut = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(opB)};
            ALU_SLL:  aluOut = srcB << idEx.shamt;
            ALU_SRL:  aluOut = srcB >> idEx.shamt;
            ALU_SRA:  aluOut = $signed(srcB) >>> idEx.shamt;
            ALU_ANDZ: aluOut = srcA & zeroImm;
            ALU_ORZ:  aluOut = srcA | zeroImm;
            ALU_XORZ: aluOut = srcA ^ zeroImm;
            default:  aluOut = srcA + opB;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!rstN || restart)
        begin
            exMem.valid <= 1'b0;
        end
        else if (run)
        begin
            exMem.valid     <= idEx.valid;
            exMem.halt      <= idEx.valid && idEx.halt;
            exMem.regWrite  <= idEx.valid && idEx.regWrite;
            exMem.memRead   <= idEx.valid && idEx.memRead;
            exMem.memWrite  <= idEx.valid && idEx.memWrite;
            exMem.destReg   <= idEx.destReg;
            exMem.aluOut    <= aluOut;
            // store data is the forwarded rt
            exMem.storeData <= srcB;
        end
    end

endmodule

`default_nettype wire

//--- src/memoryStage.sv
// data memory stage
`timescale 1ns/1ps
`include "cpuParams.svh"
`default_nettype none

module memoryStage (
    input  logic             clock,
    input  logic             rstN,
    input  logic             run,
    input  logic             restart,
    input  pipePkg::exMemT   exMem,
    input  logic [`XLEN-1:0] dataReadAddr,
    output logic [`XLEN-1:0] dataReadData,
    output pipePkg::memWbT   memWb
);

    localparam int addrBits = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] dmem [`DMEM_WORDS];
    logic [`XLEN-1:0] loadData;

    // word addressed, low two bits ignored
    assign loadData     = dmem[exMem.aluOut[addrBits+1:2]];
    assign dataReadData = dmem[dataReadAddr[addrBits+1:2]];

    always_ff @(posedge clock)
    begin
        if (run && exMem.valid && exMem.memWrite)
        begin
            dmem[exMem.aluOut[addrBits+1:2]] <= exMem.storeData;
        end
    end

    always_ff @(posedge clock)
    begin
        if (!rstN || restart)
        begin
            memWb.valid <= 1'b0;
        end
        else if (run)
        begin
            memWb.valid    <= exMem.valid;
            memWb.halt     <= exMem.valid && exMem.halt;
            memWb.regWrite <= exMem.valid && exMem.regWrite;
            memWb.destReg  <= exMem.destReg;
            memWb.result   <= exMem.memRead ? loadData : exMem.aluOut;
        end
    end

endmodule

`default_nettype wire

//--- src/hazardUnit.sv
// forwarding and stall control
`timescale 1ns/1ps
`include "cpuParams.svh"
`default_nettype none

module hazardUnit (
    input  pipePkg::ifIdT   ifId,
    input  pipePkg::idExT   idEx,
    input  pipePkg::exMemT  exMem,
    input  pipePkg::memWbT  memWb,
    output logic            stall,
    output pipePkg::fwdSelT exFwdA,
    output pipePkg::fwdSelT exFwdB,
    output pipePkg::fwdSelT idFwdA,
    output pipePkg::fwdSelT idFwdB
);

    import isaPkg::*;
    import pipePkg::*;

    opcodeT                 opcode;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic                   isBranch;
    logic                   usesRs;
    logic                   usesRt;
    logic                   exWrites;
    logic                   memWrites;
    logic                   wbWrites;
    logic                   loadUse;
    logic                   branchWait;

    // live writers, never r0
    assign exWrites  = idEx.valid && idEx.regWrite && (idEx.destReg != '0);
    assign memWrites = exMem.valid && exMem.regWrite && (exMem.destReg != '0);
    assign wbWrites  = memWb.valid && memWb.regWrite && (memWb.destReg != '0);

    // nearest older writer wins
    function automatic fwdSelT sourceOf(input logic [`REG_ADDR_W-1:0] src);
        if (memWrites && exMem.destReg == src)
            return FWD_MEM;
        if (wbWrites && memWb.destReg == src)
            return FWD_WB;
        return FWD_NONE;
    endfunction

    always_comb
    begin
        exFwdA = sourceOf(idEx.rs);
        exFwdB = sourceOf(idEx.rt);
        idFwdA = sourceOf(rs);
        idFwdB = sourceOf(rt);
    end

    // sources read by the instruction in ID
    assign opcode   = opcodeT'(ifId.instr[31:26]);
    assign rs       = ifId.instr[25:21];
    assign rt       = ifId.instr[20:16];
    assign isBranch = opcode inside {OP_BEQ, OP_BNE};
    assign usesRt   = isBranch || (opcode inside {OP_RTYPE, OP_SW});
    assign usesRs   = usesRt || (opcode inside {OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI,
                                                OP_XORI, OP_LW});

    assign loadUse = exWrites && idEx.memRead &&
                     ((usesRs && idEx.destReg == rs) || (usesRt && idEx.destReg == rt));

    // branch operands come only from MEM ALU results or WB
    assign branchWait = (exWrites && (idEx.destReg == rs || idEx.destReg == rt)) ||
                        (memWrites && exMem.memRead &&
                         (exMem.destReg == rs || exMem.destReg == rt));

    assign stall = ifId.valid && (loadUse || (isBranch && branchWait));

endmodule

`default_nettype wire

//--- src/pipelineCpu.sv
// five-stage pipelined core
`timescale 1ns/1ps
`include "cpuParams.svh"
`default_nettype none

module pipelineCpu (
    input  logic             clock,
    input  logic             rstN,
    input  logic             hostReq,
    input  pipePkg::hostCmdT hostCmd,
    output logic             hostAck,
    output logic [`XLEN-1:0] hostRdata
);

    import pipePkg::*;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        RUNNING,
        ACKED
    } hostStateT;

    hostStateT        state;
    logic             run;
    logic             restart;
    logic             imemWrite;
    logic             stall;
    ifIdT             ifId;
    idExT             idEx;
    exMemT            exMem;
    memWbT            memWb;
    fetchCtlT         fetchCtl;
    fwdSelT           exFwdA;
    fwdSelT           exFwdB;
    fwdSelT           idFwdA;
    fwdSelT           idFwdB;
    logic [`XLEN-1:0] regReadData;
    logic [`XLEN-1:0] dataReadData;

    // host handshake, BUSY is the restart cycle of a run
    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:    if (hostReq) state <= (hostCmd.op == RUN) ? BUSY : ACKED;
                BUSY:    state <= RUNNING;
                RUNNING: if (memWb.valid && memWb.halt) state <= ACKED;
                ACKED:   if (!hostReq) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign restart   = (state == BUSY);
    assign run       = (state == RUNNING);
    assign hostAck   = (state == ACKED);
    assign imemWrite = (state == IDLE) && hostReq && (hostCmd.op == LOAD_INSTR);
    assign hostRdata = (hostCmd.op == READ_REG) ? regReadData : dataReadData;

    fetchStage fetch (
        .clock(clock), .rstN(rstN), .run(run), .restart(restart), .stall(stall),
        .fetchCtl(fetchCtl), .imemWrite(imemWrite), .imemAddr(hostCmd.addr),
        .imemData(hostCmd.data), .ifId(ifId)
    );

    decodeStage decode (
        .clock(clock), .rstN(rstN), .run(run), .restart(restart), .stall(stall),
        .ifId(ifId), .wb(memWb), .memFwd(exMem), .idFwdA(idFwdA), .idFwdB(idFwdB),
        .regReadAddr(hostCmd.addr[`REG_ADDR_W-1:0]), .regReadData(regReadData),
        .idEx(idEx), .fetchCtl(fetchCtl)
    );

    executeStage execute (
        .clock(clock), .rstN(rstN), .run(run), .restart(restart), .idEx(idEx),
        .memFwd(exMem), .wbFwd(memWb), .exFwdA(exFwdA), .exFwdB(exFwdB), .exMem(exMem)
    );

    memoryStage memory (
        .clock(clock), .rstN(rstN), .run(run), .restart(restart), .exMem(exMem),
        .dataReadAddr(hostCmd.addr), .dataReadData(dataReadData), .memWb(memWb)
    );

    hazardUnit hazard (
        .ifId(ifId), .idEx(idEx), .exMem(exMem), .memWb(memWb), .stall(stall),
        .exFwdA(exFwdA), .exFwdB(exFwdB), .idFwdA(idFwdA), .idFwdB(idFwdB)
    );

endmodule

`default_nettype wire

//--- testbench/cpuTb.sv
// pipelined core testbench
`timescale 1ns/1ps
`include "cpuParams.svh"
`default_nettype none

module cpuTb;

    import isaPkg::*;
    import pipePkg::*;

    localparam logic [15:0] sentinel = 16'h5E5E;

    logic             clock;
    logic             rstN;
    logic             hostReq;
    hostCmdT          hostCmd;
    logic             hostAck;
    logic [`XLEN-1:0] hostRdata;

    // program under construction and the expected machine state
    logic [31:0] prog [$];
    logic [31:0] expReg [32];
    int          memAddrs [$];
    logic [31:0] memVals [$];

    int errors = 0;
    int checks = 0;
    int budget = 100;
    int elapsed = 0;

    pipelineCpu UUT (
        .clock(clock),
        .rstN(rstN),
        .hostReq(hostReq),
        .hostCmd(hostCmd),
        .hostAck(hostAck),
        .hostRdata(hostRdata)
    );

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // budget grows with every transfer and every program run
    initial
    begin
        while (elapsed <= budget)
        begin
            @(posedge clock);
            elapsed++;
        end
        $display("timeout: the run did not finish within %0d cycles", elapsed);
        $display("TB FAILED");
        $finish;
    end

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0t: %s: got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    // instruction encoders
    function automatic logic [31:0] rType(input functT f, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, f};
    endfunction

    function automatic logic [31:0] iType(input opcodeT op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(input opcodeT op, input logic [25:0] index);
        return {op, index};
    endfunction

    function automatic logic [31:0] memAt(input int addr);
        for (int i = 0; i < memAddrs.size(); i++)
        begin
            if (memAddrs[i] == addr)
                return memVals[i];
        end
        return '0;
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic storeExp(input int addr, input logic [31:0] value);
        memAddrs.push_back(addr);
        memVals.push_back(value);
    endtask

    // four-phase req/ack exchange, cycles counts negedges until ack
    task automatic hostXfer(input hostOpT op, input logic [31:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output int cycles);
        hostCmdT cmd;
        cmd.op   = op;
        cmd.addr = addr;
        cmd.data = data;
        budget += 16;
        @(posedge clock);
        hostCmd <= cmd;
        hostReq <= 1'b1;
        cycles = 0;
        do
        begin
            @(negedge clock);
            cycles++;
        end
        while (!hostAck);
        rdata = hostRdata;
        @(posedge clock);
        hostReq <= 1'b0;
        @(negedge clock);
        checkEq(32'(hostAck), 32'd1, "hostAck held one cycle after hostReq fell");
        while (hostAck)
            @(negedge clock);
    endtask

    task automatic loadAndRun(input string name);
        logic [31:0] unused;
        int          cycles;
        for (int i = 0; i < prog.size(); i++)
            hostXfer(LOAD_INSTR, 32'(i * 4), prog[i], unused, cycles);
        budget += prog.size() * 8;
        hostXfer(RUN, 32'd0, 32'd0, unused, cycles);
        // halt needs at least the program length plus the pipeline depth
        checkEq(32'(cycles >= prog.size() + 5), 32'd1,
                {name, ": RUN acknowledged before halt retired"});
    endtask

    task automatic verifyRegs(input string name);
        logic [31:0] rdata;
        int          cycles;
        for (int r = 0; r < 32; r++)
        begin
            hostXfer(READ_REG, 32'(r), 32'd0, rdata, cycles);
            checkEq(rdata, expReg[r], $sformatf("%s: r%0d", name, r));
        end
    endtask

    task automatic verifyMem(input string name);
        logic [31:0] rdata;
        int          cycles;
        for (int i = 0; i < memAddrs.size(); i++)
        begin
            hostXfer(READ_DATA, 32'(memAddrs[i]), 32'd0, rdata, cycles);
            checkEq(rdata, memVals[i], $sformatf("%s: word at %0d", name, memAddrs[i]));
        end
    endtask

    task automatic resetTest();
        logic [31:0] rdata;
        int          cycles;
        checkEq(32'(hostAck), 32'd0, "hostAck low after reset");
        hostXfer(READ_REG, 32'($urandom_range(31, 1)), 32'd0, rdata, cycles);
        checkEq(rdata, 32'd0, "random register after reset");
        checkEq(32'(cycles), 32'd2, "READ_REG ack in the cycle after the request");
        verifyRegs("reset");
    endtask

    task automatic aluTest();
        logic [15:0] a16;
        logic [15:0] b16;
        logic [15:0] imm;
        logic [4:0]  sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sImm;
        logic [31:0] zImm;
        a16  = 16'($urandom);
        b16  = 16'($urandom);
        imm  = 16'($urandom);
        sh   = 5'($urandom_range(31, 1));
        a    = {{16{a16[15]}}, a16};
        b    = {16'h0000, b16};
        sImm = {{16{imm[15]}}, imm};
        zImm = {16'h0000, imm};
        prog.delete();
        emit(iType(OP_ADDI, 0, 1, a16));
        emit(iType(OP_ORI, 0, 2, b16));
        emit(rType(F_ADD, 1, 2, 3, 0));
        emit(rType(F_ADDU, 1, 2, 4, 0));
        emit(rType(F_SUB, 1, 2, 5, 0));
        emit(rType(F_SUBU, 2, 1, 6, 0));
        emit(rType(F_AND, 1, 2, 7, 0));
        emit(rType(F_OR, 1, 2, 8, 0));
        emit(rType(F_XOR, 1, 2, 9, 0));
        emit(rType(F_NOR, 1, 2, 10, 0));
        emit(rType(F_SLT, 1, 2, 11, 0));
        emit(rType(F_SLT, 2, 1, 12, 0));
        // shifts take rt and shamt
        emit(rType(F_SLL, 0, 1, 13, sh));
        emit(rType(F_SRL, 0, 1, 14, sh));
        emit(rType(F_SRA, 0, 1, 15, sh));
        emit(iType(OP_ADDI, 1, 16, imm));
        emit(iType(OP_ADDIU, 2, 17, imm));
        emit(iType(OP_ANDI, 1, 18, imm));
        emit(iType(OP_ORI, 1, 19, imm));
        emit(iType(OP_XORI, 1, 20, imm));
        emit(`HALT_WORD);
        expReg[1]  = a;
        expReg[2]  = b;
        expReg[3]  = a + b;
        expReg[4]  = a + b;
        expReg[5]  = a - b;
        expReg[6]  = b - a;
        expReg[7]  = a & b;
        expReg[8]  = a | b;
        expReg[9]  = a ^ b;
        expReg[10] = ~(a | b);
        expReg[11] = 32'($signed(a) < $signed(b));
        expReg[12] = 32'($signed(b) < $signed(a));
        expReg[13] = a << sh;
        expReg[14] = a >> sh;
        expReg[15] = $signed(a) >>> sh;
        expReg[16] = a + sImm;
        expReg[17] = b + sImm;
        // logical immediates are zero-extended
        expReg[18] = a & zImm;
        expReg[19] = a | zImm;
        expReg[20] = a ^ zImm;
        loadAndRun("alu");
        verifyRegs("alu");
    endtask

    task automatic forwardTest();
        logic [15:0] x16;
        logic [15:0] y16;
        x16 = 16'($urandom);
        y16 = 16'($urandom);
        prog.delete();
        emit(iType(OP_ADDI, 0, 21, x16));
        expReg[21] = {{16{x16[15]}}, x16};
        emit(iType(OP_ORI, 0, 22, y16));
        expReg[22] = {16'h0000, y16};
        // each result feeds the next instruction
        emit(rType(F_ADD, 21, 22, 23, 0));
        expReg[23] = expReg[21] + expReg[22];
        emit(rType(F_SUB, 23, 21, 24, 0));
        expReg[24] = expReg[23] - expReg[21];
        emit(rType(F_XOR, 24, 23, 25, 0));
        expReg[25] = expReg[24] ^ expReg[23];
        emit(rType(F_ADD, 25, 25, 26, 0));
        expReg[26] = expReg[25] + expReg[25];
        emit(rType(F_SUBU, 26, 24, 23, 0));
        expReg[23] = expReg[26] - expReg[24];
        emit(rType(F_XOR, 23, 26, 24, 0));
        expReg[24] = expReg[23] ^ expReg[26];
        emit(`HALT_WORD);
        loadAndRun("forward");
        verifyRegs("forward");
    endtask

    task automatic memoryTest();
        prog.delete();
        emit(iType(OP_ADDI, 0, 27, 16'd64));
        expReg[27] = 32'd64;
        emit(iType(OP_SW, 27, 23, 16'd0));
        storeExp(64, expReg[23]);
        emit(iType(OP_SW, 27, 24, 16'd4));
        storeExp(68, expReg[24]);
        emit(iType(OP_SW, 27, 25, 16'd8));
        storeExp(72, expReg[25]);
        // load then an immediate use, one bubble each
        emit(iType(OP_LW, 27, 28, 16'd4));
        expReg[28] = memAt(68);
        emit(rType(F_ADD, 28, 23, 29, 0));
        expReg[29] = expReg[28] + expReg[23];
        emit(iType(OP_LW, 27, 30, 16'd8));
        expReg[30] = memAt(72);
        emit(rType(F_ADDU, 30, 28, 31, 0));
        expReg[31] = expReg[30] + expReg[28];
        emit(iType(OP_SW, 27, 31, 16'd12));
        storeExp(76, expReg[31]);
        emit(`HALT_WORD);
        loadAndRun("memory");
        verifyRegs("memory");
        verifyMem("memory");
    endtask

    // skipped slots write the sentinel, so those registers must keep old values
    task automatic controlTest();
        prog.delete();
        emit(iType(OP_ADDI, 0, 1, 16'd7));
        expReg[1] = 32'd7;
        emit(iType(OP_ADDI, 0, 2, 16'd7));
        expReg[2] = 32'd7;
        emit(iType(OP_BEQ, 1, 2, 16'd2));
        emit(iType(OP_ADDI, 0, 3, sentinel));
        emit(iType(OP_ADDI, 0, 4, sentinel));
        emit(iType(OP_ADDI, 0, 5, 16'd11));
        expReg[5] = 32'd11;
        emit(iType(OP_BNE, 1, 2, 16'd1));
        emit(iType(OP_ADDI, 0, 11, 16'd13));
        expReg[11] = 32'd13;
        emit(iType(OP_BEQ, 1, 5, 16'd1));
        emit(iType(OP_ADDI, 0, 12, 16'd14));
        expReg[12] = 32'd14;
        emit(iType(OP_BNE, 1, 5, 16'd1));
        emit(iType(OP_ADDI, 0, 6, sentinel));
        // branch on a freshly loaded word
        emit(iType(OP_SW, 0, 1, 16'd80));
        storeExp(80, 32'd7);
        emit(iType(OP_ADDI, 0, 7, 16'd0));
        emit(iType(OP_LW, 0, 7, 16'd80));
        expReg[7] = 32'd7;
        emit(iType(OP_BEQ, 7, 1, 16'd1));
        emit(iType(OP_ADDI, 0, 8, sentinel));
        emit(jType(OP_J, 26'(prog.size() + 2)));
        emit(iType(OP_ADDI, 0, 9, sentinel));
        emit(iType(OP_ADDI, 0, 10, 16'd12));
        expReg[10] = 32'd12;
        emit(`HALT_WORD);
        loadAndRun("control");
        verifyRegs("control");
        verifyMem("control");
    endtask

    // previous halt still sits in MEM/WB until restart clears it
    task automatic rerunTest();
        prog.delete();
        emit(rType(F_ADD, 10, 11, 13, 0));
        expReg[13] = expReg[10] + expReg[11];
        emit(iType(OP_LW, 0, 14, 16'd68));
        expReg[14] = memAt(68);
        emit(iType(OP_SW, 0, 13, 16'd84));
        storeExp(84, expReg[13]);
        emit(`HALT_WORD);
        loadAndRun("rerun");
        verifyRegs("rerun");
        verifyMem("rerun");
    endtask

    initial
    begin
        void'($urandom(32'hfb24));
        for (int r = 0; r < 32; r++)
            expReg[r] = '0;
        rstN    <= 1'b0;
        hostReq <= 1'b0;
        hostCmd <= '0;
        repeat (3) @(posedge clock);
        rstN <= 1'b1;
        @(negedge clock);
        resetTest();
        aluTest();
        forwardTest();
        memoryTest();
        controlTest();
        rerunTest();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/isaPkg.sv
src/pipePkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/hazardUnit.sv
src/pipelineCpu.sv
testbench/cpuTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module cpuTb -o cpuSim
./obj_dir/cpuSim | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
